// ==== armPipePkg.sv ====
package armPipePkg;

  // Register index width of the ARM register file
  localparam int regAddrW = 4;

  typedef logic [regAddrW-1:0] regAddrT;

  // Operand source for the execute stage
  typedef enum logic [1:0] {
    fwdNone  = 2'b00,
    fwdFromW = 2'b01,
    fwdFromM = 2'b10
  } fwdSelT;

  // PC offset saved on exception entry
  typedef enum logic [1:0] {
    pcInPlus8 = 2'b00,
    pcInPlus4 = 2'b01,
    pcInPlus0 = 2'b10
  } pcInSelT;

  // Per-instruction descriptor carried down the pipe
  typedef struct packed {
    logic    valid;
    regAddrT srcA;
    regAddrT srcB;
    regAddrT dest;
    logic    usesA;
    logic    usesB;
    logic    regWrite;
    logic    memToReg;
    // Software interrupt and undefined opcode
    logic    swi;
    logic    undef;
    // MSR and MRS style status register access
    logic    regToCpsr;
    logic    cpsrToReg;
  } instrDescT;

  // Empty slot loaded on flush and bubble insertion
  localparam instrDescT bubbleDesc = '0;

  // Register compare results, regWrite not yet applied
  typedef struct packed {
    logic match1EM;
    logic match1EW;
    logic match2EM;
    logic match2EW;
    logic match1DE;
    logic match2DE;
  } matchT;

  // Flags taken from stage contents, each qualified by valid
  typedef struct packed {
    logic regWriteM;
    logic regWriteW;
    logic memToRegE;
    logic swiD;
    logic swiE;
    logic swiM;
    logic swiW;
    logic undefD;
    logic undefE;
    logic undefM;
    logic undefW;
    logic regToCpsrD;
    logic cpsrToRegD;
  } stageFlagsT;

  // Exception requests in priority order
  typedef struct packed {
    logic prefetchAbort;
    logic dataAbort;
    logic irq;
    logic fiq;
    logic undefinedInstr;
    logic swi;
  } excReqT;

  // External stall and flow levels
  typedef struct packed {
    logic dStall;
    logic iStall;
    logic multStallD;
    logic uOpStallD;
    logic pcWrPendingF;
    logic ldmStmForwardE;
  } stallReqT;

  // Stall and flush network towards the stage registers
  typedef struct packed {
    logic stallF;
    logic stallD;
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushD;
    logic flushE;
    logic flushW;
  } pipeCtrlT;

endpackage

// ==== operandMatch.sv ====
`timescale 1ns/1ps

module operandMatch
  import armPipePkg::*;
(
  input  instrDescT descD,
  input  instrDescT descE,
  input  instrDescT descM,
  input  instrDescT descW,
  output matchT     match
);

  // One reader operand against one writer stage
  function automatic logic regHit(
    input logic      readValid,
    input logic      readUses,
    input regAddrT   readSrc,
    input instrDescT writer
  );
    logic hit;
    // Both slots must hold real instructions
    hit = readValid & writer.valid;
    // Reader must actually consume the operand
    hit = hit & readUses;
    // Same architectural register
    hit = hit & (writer.dest == readSrc);
    return hit;
  endfunction

  always_comb begin
    // Execute operand A against memory and writeback
    match.match1EM = regHit(descE.valid, descE.usesA, descE.srcA, descM);
    match.match1EW = regHit(descE.valid, descE.usesA, descE.srcA, descW);

    // Execute operand B against memory and writeback
    match.match2EM = regHit(descE.valid, descE.usesB, descE.srcB, descM);
    match.match2EW = regHit(descE.valid, descE.usesB, descE.srcB, descW);

    // Decode sources against execute, used for load-use detection
    match.match1DE = regHit(descD.valid, descD.usesA, descD.srcA, descE);
    match.match2DE = regHit(descD.valid, descD.usesB, descD.srcB, descE);
  end

endmodule

// ==== hazard.sv ====
`timescale 1ns/1ps

module hazard
  import armPipePkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  matchT      match,
  input  stageFlagsT stageFlags,
  input  stallReqT   stallReq,
  input  excReqT     excReq,
  input  logic       branchTakenE,
  input  logic       pcSrcW,
  output fwdSelT     fwdAE,
  output fwdSelT     fwdBE,
  output logic       incrementE,
  output logic       stallUop,
  output logic       exceptionSavePC,
  output pipeCtrlT   pipeCtrl,
  output pcInSelT    pcInSelect
);

  logic ldrStallD;
  logic memStall;
  logic excInE;
  logic excInM;
  logic cpsrAccessD;
  logic excOlderThanD;

  // Memory wins over writeback for operand A
  always_comb begin
    if ((match.match1EM & stageFlags.regWriteM) | stallReq.ldmStmForwardE) begin
      fwdAE = fwdFromM;
    end else if (match.match1EW & stageFlags.regWriteW) begin
      fwdAE = fwdFromW;
    end else begin
      fwdAE = fwdNone;
    end
  end

  // Same priority for operand B without the LDM/STM override
  always_comb begin
    if (match.match2EM & stageFlags.regWriteM) begin
      fwdBE = fwdFromM;
    end else if (match.match2EW & stageFlags.regWriteW) begin
      fwdBE = fwdFromW;
    end else begin
      fwdBE = fwdNone;
    end
  end

  // Address walk for block transfers
  assign incrementE = stallReq.ldmStmForwardE;

  // Load result not ready for the reader in decode
  assign ldrStallD = (match.match1DE | match.match2DE) & stageFlags.memToRegE;

  // Data or instruction memory not ready
  assign memStall = stallReq.dStall | stallReq.iStall;

  // SWI or undefined sitting in execute or memory
  assign excInE = stageFlags.swiE | stageFlags.undefE;
  assign excInM = stageFlags.swiM | stageFlags.undefM;

  assign cpsrAccessD = stageFlags.regToCpsrD | stageFlags.cpsrToRegD;

  // Exception anywhere behind decode
  assign excOlderThanD = excInE | excInM | stageFlags.swiW | stageFlags.undefW;

  always_comb begin
    // Fetch freezes for every hazard plus pending PC writes and exceptions
    pipeCtrl.stallF = ldrStallD | stallReq.pcWrPendingF | memStall
                    | stallReq.uOpStallD | stallReq.multStallD
                    | stageFlags.swiD | stageFlags.undefD
                    | excInE | excInM | cpsrAccessD;

    pipeCtrl.stallD = ldrStallD | memStall | stallReq.uOpStallD
                    | stallReq.multStallD | excInE;

    // Later stages only wait for memory
    pipeCtrl.stallE = memStall;
    pipeCtrl.stallM = memStall;
    pipeCtrl.stallW = memStall;

    // Writeback drains after its report while memory stalls
    pipeCtrl.flushW = memStall;

    // Execute empties on load-use or on the wrong path after a taken branch
    pipeCtrl.flushE = ldrStallD | branchTakenE | excInM;

    pipeCtrl.flushD = stallReq.pcWrPendingF | pcSrcW | branchTakenE
                    | excOlderThanD | cpsrAccessD;
  end

  // Micro-op sequencer holds on these only
  assign stallUop = ldrStallD | memStall | stallReq.multStallD;

  // Return address captured when the exception reaches execute
  assign exceptionSavePC = excInE;

  // Exception entry PC offset by priority
  always_comb begin
    if (excReq.prefetchAbort) begin
      pcInSelect = pcInPlus8;
    end else if (excReq.dataAbort) begin
      pcInSelect = pcInPlus0;
    end else if (excReq.irq) begin
      pcInSelect = pcInPlus8;
    end else if (excReq.fiq) begin
      pcInSelect = pcInPlus8;
    end else if (excReq.undefinedInstr) begin
      pcInSelect = pcInPlus4;
    end else if (excReq.swi) begin
      // Link write for SWI travels one cycle late
      pcInSelect = pcInPlus0;
    end else begin
      pcInSelect = pcInPlus8;
    end
  end

  // The bubble behind a load clears the load-use hazard by the next cycle
  assert property (@(posedge clk) disable iff (!rstN)
    ldrStallD |=> !ldrStallD);

  // An SWI or undefined in execute moves on unless memory stalls
  assert property (@(posedge clk) disable iff (!rstN)
    (excInE && !memStall) |=> !excInE);

endmodule

// ==== pipeTracker.sv ====
`timescale 1ns/1ps

module pipeTracker
  import armPipePkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  instrDescT  fetchDesc,
  input  pipeCtrlT   pipeCtrl,
  output instrDescT  descD,
  output instrDescT  descE,
  output instrDescT  descM,
  output instrDescT  descW,
  output stageFlagsT stageFlags,
  output logic       retireValid,
  output instrDescT  retireDesc
);

  instrDescT nextD;
  instrDescT nextE;
  instrDescT nextM;
  instrDescT nextW;

  // Decode stage
  always_comb begin
    if (pipeCtrl.flushD) begin
      nextD = bubbleDesc;
    end else if (pipeCtrl.stallD) begin
      nextD = descD;
    end else if (pipeCtrl.stallF) begin
      // Held fetch slot is not accepted so decode empties
      nextD = bubbleDesc;
    end else begin
      nextD = fetchDesc;
    end
  end

  // Execute stage
  always_comb begin
    if (pipeCtrl.flushE) begin
      nextE = bubbleDesc;
    end else if (pipeCtrl.stallE) begin
      nextE = descE;
    end else if (pipeCtrl.stallD) begin
      // Decode stalls alone so a bubble moves on
      nextE = bubbleDesc;
    end else begin
      nextE = descD;
    end
  end

  // Memory stage has no flush
  always_comb begin
    if (pipeCtrl.stallM) begin
      nextM = descM;
    end else begin
      nextM = descE;
    end
  end

  // Writeback stage
  always_comb begin
    if (pipeCtrl.flushW) begin
      nextW = bubbleDesc;
    end else if (pipeCtrl.stallW) begin
      nextW = descW;
    end else begin
      nextW = descM;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      descD <= bubbleDesc;
      descE <= bubbleDesc;
      descM <= bubbleDesc;
      descW <= bubbleDesc;
    end else begin
      descD <= nextD;
      descE <= nextE;
      descM <= nextM;
      descW <= nextW;
    end
  end

  // Flags back to hazard masked by slot valid
  always_comb begin
    stageFlags.regWriteM  = descM.valid & descM.regWrite;
    stageFlags.regWriteW  = descW.valid & descW.regWrite;
    stageFlags.memToRegE  = descE.valid & descE.memToReg;
    stageFlags.swiD       = descD.valid & descD.swi;
    stageFlags.swiE       = descE.valid & descE.swi;
    stageFlags.swiM       = descM.valid & descM.swi;
    stageFlags.swiW       = descW.valid & descW.swi;
    stageFlags.undefD     = descD.valid & descD.undef;
    stageFlags.undefE     = descE.valid & descE.undef;
    stageFlags.undefM     = descM.valid & descM.undef;
    stageFlags.undefW     = descW.valid & descW.undef;
    stageFlags.regToCpsrD = descD.valid & descD.regToCpsr;
    stageFlags.cpsrToRegD = descD.valid & descD.cpsrToReg;
  end

  // Report whatever sits in writeback this cycle
  assign retireValid = descW.valid;
  assign retireDesc  = descW;

  // Decode held while fetch moves on would drop the fetched instruction
  assert property (@(posedge clk) disable iff (!rstN)
    pipeCtrl.stallD |-> pipeCtrl.stallF);

  // No instruction is reported twice during a memory stall
  assert property (@(posedge clk) disable iff (!rstN)
    (pipeCtrl.stallW && descW.valid) |=> !descW.valid);

endmodule

// ==== pipeControlTop.sv ====
`timescale 1ns/1ps

module pipeControlTop
  import armPipePkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  instrDescT fetchDesc,
  input  stallReqT  stallReq,
  input  excReqT    excReq,
  input  logic      branchTakenE,
  input  logic      pcSrcW,
  output fwdSelT    fwdAE,
  output fwdSelT    fwdBE,
  output logic      incrementE,
  output pipeCtrlT  pipeCtrl,
  output logic      stallUop,
  output logic      exceptionSavePC,
  output pcInSelT   pcInSelect,
  output logic      retireValid,
  output instrDescT retireDesc
);

  // Stage contents stay inside the block
  instrDescT  descD;
  instrDescT  descE;
  instrDescT  descM;
  instrDescT  descW;
  matchT      match;
  stageFlagsT stageFlags;

  // Register compares between stages
  operandMatch operandMatch_i (
    .descD (descD),
    .descE (descE),
    .descM (descM),
    .descW (descW),
    .match (match)
  );

  // Forwarding, stall and flush decisions
  hazard hazard_i (
    .clk             (clk),
    .rstN            (rstN),
    .match           (match),
    .stageFlags      (stageFlags),
    .stallReq        (stallReq),
    .excReq          (excReq),
    .branchTakenE    (branchTakenE),
    .pcSrcW          (pcSrcW),
    .fwdAE           (fwdAE),
    .fwdBE           (fwdBE),
    .incrementE      (incrementE),
    .stallUop        (stallUop),
    .exceptionSavePC (exceptionSavePC),
    .pipeCtrl        (pipeCtrl),
    .pcInSelect      (pcInSelect)
  );

  // Stage registers and retire report
  pipeTracker pipeTracker_i (
    .clk         (clk),
    .rstN        (rstN),
    .fetchDesc   (fetchDesc),
    .pipeCtrl    (pipeCtrl),
    .descD       (descD),
    .descE       (descE),
    .descM       (descM),
    .descW       (descW),
    .stageFlags  (stageFlags),
    .retireValid (retireValid),
    .retireDesc  (retireDesc)
  );

endmodule

// ==== tbPipeControl.sv ====
`timescale 1ns/1ps

module tbPipeControl
  import armPipePkg::*;
();

  // Cycle budget of one test that the watchdog sums over all tests
  localparam int testCycles = 60;
  localparam int numTests = 6;
  localparam int clkPeriod = 4;

  logic      clk = 1'b0;
  logic      rstN = 1'b0;
  instrDescT fetchDesc = '0;
  stallReqT  stallReq = '0;
  excReqT    excReq = '0;
  logic      branchTakenE = 1'b0;
  logic      pcSrcW = 1'b0;
  fwdSelT    fwdAE;
  fwdSelT    fwdBE;
  logic      incrementE;
  logic      stallUop;
  logic      exceptionSavePC;
  logic      retireValid;
  pipeCtrlT  pipeCtrl;
  pcInSelT   pcInSelect;
  instrDescT retireDesc;

  // Stage model, fetch queue and scoreboard
  instrDescT mD = '0;
  instrDescT mE = '0;
  instrDescT mM = '0;
  instrDescT mW = '0;
  instrDescT feedQ[$];
  instrDescT sbQ[$];
  int        acceptCyc[$];
  int        cyc = 0;
  int        seed = 10;
  int        errCount = 0;
  int        retired = 0;
  logic      quietRun = 1'b0;

  // Expected responses
  fwdSelT   expFwdA;
  fwdSelT   expFwdB;
  pcInSelT  expPcIn;
  pipeCtrlT mustSet;
  logic     loadUse;
  logic     excE;
  logic     excAny;
  logic     cpsrD;
  logic     memStall;
  logic     quiet;

  always #2 clk = ~clk;

  pipeControlTop pipeControlTop_i (.*);

  task automatic valueErr(input string name, input logic [31:0] expV, input logic [31:0] gotV);
    errCount++;
    $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, name, expV, gotV);
  endtask

  // Memory wins over writeback and LDM/STM forces memory
  function automatic fwdSelT pickFwd(input logic uses, input regAddrT src, input logic ldm,
                                     input instrDescT e, input instrDescT m, input instrDescT w);
    logic rd;
    rd = e.valid && uses;
    if (ldm || (rd && m.valid && m.regWrite && m.dest == src)) begin
      return fwdFromM;
    end else if (rd && w.valid && w.regWrite && w.dest == src) begin
      return fwdFromW;
    end
    return fwdNone;
  endfunction

  always_comb begin
    expFwdA = pickFwd(mE.usesA, mE.srcA, stallReq.ldmStmForwardE, mE, mM, mW);
    expFwdB = pickFwd(mE.usesB, mE.srcB, 1'b0, mE, mM, mW);
    loadUse = mD.valid && mE.valid && mE.memToReg
              && ((mD.usesA && mD.srcA == mE.dest) || (mD.usesB && mD.srcB == mE.dest));
    excE = mE.valid && (mE.swi || mE.undef);
    excAny = excE || (mD.valid && (mD.swi || mD.undef)) || (mM.valid && (mM.swi || mM.undef))
             || (mW.valid && (mW.swi || mW.undef));
    cpsrD = mD.valid && (mD.regToCpsr || mD.cpsrToReg);
    memStall = stallReq.dStall || stallReq.iStall;
    quiet = !(|stallReq) && !branchTakenE && !pcSrcW && !loadUse && !excAny && !cpsrD;
    // Lower bound on the stall and flush bits for each cause
    mustSet.stallF = loadUse | stallReq.pcWrPendingF | memStall | excE | cpsrD;
    mustSet.stallD = loadUse | memStall | excE;
    mustSet.stallE = memStall;
    mustSet.stallM = memStall;
    mustSet.stallW = memStall;
    mustSet.flushD = branchTakenE | stallReq.pcWrPendingF | pcSrcW | cpsrD;
    mustSet.flushE = loadUse | branchTakenE;
    mustSet.flushW = memStall;
    // Exception entry offset with prefetch abort first
    casez (excReq)
      6'b1?????: expPcIn = pcInPlus8;
      6'b01????: expPcIn = pcInPlus0;
      6'b001???, 6'b0001??: expPcIn = pcInPlus8;
      6'b00001?: expPcIn = pcInPlus4;
      6'b000001: expPcIn = pcInPlus0;
      default: expPcIn = pcInPlus8;
    endcase
  end

  // Flush first, then stall, then load the older stage
  always @(posedge clk) begin
    if (!rstN) begin
      mD <= bubbleDesc;
      mE <= bubbleDesc;
      mM <= bubbleDesc;
      mW <= bubbleDesc;
    end else begin
      mD <= pipeCtrl.flushD ? bubbleDesc : pipeCtrl.stallD ? mD
            : pipeCtrl.stallF ? bubbleDesc : fetchDesc;
      mE <= pipeCtrl.flushE ? bubbleDesc : pipeCtrl.stallE ? mE
            : pipeCtrl.stallD ? bubbleDesc : mD;
      mM <= pipeCtrl.stallM ? mM : mE;
      mW <= pipeCtrl.flushW ? bubbleDesc : pipeCtrl.stallW ? mW : mM;
    end
  end

  // Fetch driver and scoreboard
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rstN) begin
      fetchDesc <= bubbleDesc;
    end else begin
      if (retireValid && sbQ.size() == 0) begin
        errCount++;
        $display("Retire at %0t with no outstanding instruction", $time);
      end else if (retireValid) begin
        if (retireDesc != sbQ[0]) begin
          valueErr("retireDesc", 32'(sbQ[0]), 32'(retireDesc));
        end else if (quietRun && cyc - acceptCyc[0] != 4) begin
          errCount++;
          $display("Retire at %0t took %0d edges instead of 4", $time, cyc - acceptCyc[0]);
        end
        void'(sbQ.pop_front());
        void'(acceptCyc.pop_front());
        retired++;
      end
      // A held decode slot killed by flushD is the youngest entry
      if (pipeCtrl.flushD && pipeCtrl.stallD && mD.valid) begin
        void'(sbQ.pop_back());
        void'(acceptCyc.pop_back());
      end
      // Whatever would have entered execute dies on flushE
      if (pipeCtrl.flushE && (pipeCtrl.stallE ? mE.valid : (!pipeCtrl.stallD && mD.valid))) begin
        if (pipeCtrl.stallE && mD.valid && !pipeCtrl.flushD) begin
          sbQ.delete(sbQ.size() - 2);
          acceptCyc.delete(acceptCyc.size() - 2);
        end else begin
          void'(sbQ.pop_back());
          void'(acceptCyc.pop_back());
        end
      end
      if (!pipeCtrl.stallF && !pipeCtrl.flushD && fetchDesc.valid) begin
        sbQ.push_back(fetchDesc);
        acceptCyc.push_back(cyc);
      end
      // Held while fetch stalls
      if (!pipeCtrl.stallF) begin
        fetchDesc <= (feedQ.size() > 0) ? feedQ.pop_front() : bubbleDesc;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) {fwdAE, fwdBE} == {expFwdA, expFwdB})
    else valueErr("fwdAE/fwdBE", 32'($sampled({expFwdA, expFwdB})),
                  32'($sampled({fwdAE, fwdBE})));
  assert property (@(posedge clk) disable iff (!rstN) incrementE == stallReq.ldmStmForwardE)
    else valueErr("incrementE", 32'($sampled(stallReq.ldmStmForwardE)),
                  32'($sampled(incrementE)));
  assert property (@(posedge clk) disable iff (!rstN) pcInSelect == expPcIn)
    else valueErr("pcInSelect", 32'($sampled(expPcIn)), 32'($sampled(pcInSelect)));
  // Quiet pipe means no control at all and otherwise the causes must show
  assert property (@(posedge clk) disable iff (!rstN)
    quiet ? (pipeCtrl == '0 && !stallUop) : ((pipeCtrl & mustSet) == mustSet))
    else valueErr("pipeCtrl", 32'($sampled(mustSet)), 32'($sampled(pipeCtrl)));
  // Without an exception in flight decode is flushed for these causes only
  assert property (@(posedge clk) disable iff (!rstN)
    !excAny |-> (pipeCtrl.flushD == mustSet.flushD))
    else valueErr("flushD", 32'($sampled(mustSet.flushD)), 32'($sampled(pipeCtrl.flushD)));
  assert property (@(posedge clk) disable iff (!rstN) exceptionSavePC == excE)
    else valueErr("exceptionSavePC", 32'($sampled(excE)), 32'($sampled(exceptionSavePC)));
  assert property (@(posedge clk) disable iff (!rstN) loadUse |=> !loadUse)
    else begin
      errCount++;
      $display("Load-use stall at %0t lasted more than one cycle", $time);
    end
  assert property (@(posedge clk) disable iff (!rstN) retireValid == mW.valid)
    else valueErr("retireValid", 32'($sampled(mW.valid)), 32'($sampled(retireValid)));

  task automatic makeDesc(output instrDescT d, input logic ld);
    logic [31:0] r;
    r = $random(seed);
    d = bubbleDesc;
    d.valid = 1'b1;
    d.srcA = r[3:0];
    d.srcB = r[7:4];
    d.dest = r[11:8];
    d.usesA = r[12];
    d.usesB = r[13];
    d.regWrite = r[14] | ld;
    d.memToReg = ld;
  endtask

  task automatic pushRandom(input int n);
    instrDescT d;
    repeat (n) begin
      makeDesc(d, 1'b0);
      feedQ.push_back(d);
    end
  endtask

  // Wait until nothing is queued or in flight within the test budget
  task automatic waitDrain(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while ((feedQ.size() > 0 || fetchDesc.valid || sbQ.size() > 0) && n < testCycles) begin
      @(negedge clk);
      n++;
    end
    if (n == testCycles) begin
      errCount++;
      $display("Test %s: pipe did not drain, %0d instructions outstanding", name, sbQ.size());
    end
    $display("Test %s finished, %0d errors so far", name, errCount);
  endtask

  initial begin
    logic [31:0] r;
    instrDescT   w1;
    instrDescT   rd;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    repeat (3) @(posedge clk);
    quietRun <= 1'b1;
    @(negedge clk);
    pushRandom(8);
    waitDrain("reset");
    quietRun <= 1'b0;

    // Writer pairs at distance 1 and 2, then a writer without regWrite
    makeDesc(w1, 1'b0);
    w1.regWrite = 1'b1;
    makeDesc(rd, 1'b0);
    rd.srcA = w1.dest;
    rd.srcB = w1.dest;
    rd.usesA = 1'b1;
    rd.usesB = 1'b1;
    feedQ = {w1, w1, rd, w1, bubbleDesc, rd};
    w1.regWrite = 1'b0;
    feedQ.push_back(w1);
    feedQ.push_back(rd);
    repeat (12) @(posedge clk);
    stallReq.ldmStmForwardE <= 1'b1;
    repeat (3) @(posedge clk);
    stallReq.ldmStmForwardE <= 1'b0;
    waitDrain("forward");

    // Load with a dependent reader right behind it
    makeDesc(w1, 1'b1);
    makeDesc(rd, 1'b0);
    rd.srcB = w1.dest;
    rd.usesB = 1'b1;
    feedQ = {w1, rd};
    pushRandom(3);
    waitDrain("load-use");

    pushRandom(6);
    repeat (5) @(posedge clk);
    branchTakenE <= 1'b1;
    @(posedge clk);
    branchTakenE <= 1'b0;
    @(negedge clk);
    pushRandom(4);
    @(posedge clk);
    stallReq.pcWrPendingF <= 1'b1;
    repeat (2) @(posedge clk);
    stallReq.pcWrPendingF <= 1'b0;
    pcSrcW <= 1'b1;
    @(posedge clk);
    pcSrcW <= 1'b0;
    waitDrain("branch");

    pushRandom(10);
    repeat (20) begin
      @(posedge clk);
      r = $random(seed);
      stallReq.dStall <= r[0] & r[1];
      stallReq.iStall <= r[2] & r[3];
    end
    @(posedge clk);
    stallReq <= '0;
    waitDrain("memory stall");

    repeat (16) begin
      @(posedge clk);
      r = $random(seed);
      excReq <= r[5:0];
    end
    @(posedge clk);
    excReq <= '0;
    @(negedge clk);
    // SWI, undefined, then both CPSR access kinds
    makeDesc(w1, 1'b0);
    w1.swi = 1'b1;
    feedQ.push_back(w1);
    pushRandom(2);
    w1.swi = 1'b0;
    w1.undef = 1'b1;
    feedQ.push_back(w1);
    w1.undef = 1'b0;
    w1.regToCpsr = 1'b1;
    feedQ.push_back(w1);
    w1.regToCpsr = 1'b0;
    w1.cpsrToReg = 1'b1;
    feedQ.push_back(w1);
    pushRandom(2);
    waitDrain("exception");

    $display("Checks failed: %0d, instructions retired: %0d", errCount, retired);
    if (errCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog over all test budgets plus margin
  initial begin
    #(numTests * testCycles * clkPeriod * 2 + 200);
    $display("Timeout: the run did not reach its end in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== files.f ====
armPipePkg.sv
operandMatch.sv
hazard.sv
pipeTracker.sv
pipeControlTop.sv
tbPipeControl.sv
